/* Makefile */
# Verilator flow for the MSP430 core testbench
VERILATOR ?= verilator
TOP       ?= msp430CoreTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LINTFLAGS ?= --lint-only -Wall --timing
SIMFLAGS  ?= --binary --timing --assert -j 0
PASSMSG   ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR) -o $(TOP)

# Pass only when the simulation output holds the pass message
sim: build
	@out="$$(./$(OBJDIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

/* list.f */
source/msp430Pkg.sv
source/coreIfs.sv
source/instrFetch.sv
source/instrDecoder.sv
source/regFile.sv
source/funcUnit.sv
source/msp430Core.sv
testbench/msp430CoreChecker_checker.sv
testbench/msp430CoreTb.sv

/* source/coreIfs.sv */
// Internal buses of the core; only one word or instruction is in flight
interface fetchIf;
   import msp430Pkg::*;

   // Decoder side
   logic       wordReq;
   logic       redirect;
   // Jump offset in words, sign-extended by the fetch unit
   logic [9:0] offset;
   // Fetch side
   logic       wordValid;
   word_t      word;
   word_t      pc;

   modport decoder (output wordReq, redirect, offset, input wordValid, word, pc);
   modport fetcher (input wordReq, redirect, offset, output wordValid, word, pc);
endinterface

interface execIf;
   import msp430Pkg::*;

   logic     start;
   funcSel_t fs;
   regAddr_t srcReg;
   regAddr_t dstReg;
   logic     useImm;
   word_t    immediate;
   logic     regWrite;
   // done trails start by one cycle, taken is valid with done
   logic     done;
   logic     taken;

   modport decoder (output start, fs, srcReg, dstReg, useImm, immediate, regWrite,
                    input done, taken);
   modport alu (input start, fs, dstReg, useImm, immediate, regWrite, output done, taken);
   modport regs (input srcReg, dstReg, regWrite, done);
endinterface

/* source/funcUnit.sv */
// Word-wide ALU with MSP430 flag rules; result and flags register on start
// done and taken follow start by one cycle
module funcUnit
   (input  logic                clk,
    input  logic                rstN,
    execIf.alu                  exec,
    input  msp430Pkg::word_t    rdA,
    input  msp430Pkg::word_t    rdB,
    output msp430Pkg::word_t    wbData,
    output logic                wbValid,
    output msp430Pkg::regAddr_t wbReg,
    output msp430Pkg::flags_t   flags);

   import msp430Pkg::*;

   // Source operand, immediate word or register
   word_t       srcOp;
   // Second adder input, inverted for subtraction
   word_t       addB;
   logic        carryIn;
   logic [16:0] sum;
   word_t       result;
   flags_t      nextFlags;
   // Jump condition against the current flags
   logic        condMet;

   assign srcOp = exec.useImm ? exec.immediate : rdA;

   // Subtraction runs as dst + ~src + carry-in
   always_comb
   begin
      addB    = srcOp;
      carryIn = 1'b0;
      case (exec.fs)
         FS_ADDC:
            carryIn = flags[FLAG_C];
         FS_SUB, FS_CMP:
         begin
            addB    = ~srcOp;
            carryIn = 1'b1;
         end
         FS_SUBC:
         begin
            addB    = ~srcOp;
            carryIn = flags[FLAG_C];
         end
         default:
            carryIn = 1'b0;
      endcase
   end

   assign sum = {1'b0, rdB} + {1'b0, addB} + {16'h0, carryIn};

   always_comb
   begin
      result    = rdB;
      nextFlags = flags;
      case (exec.fs)
         FS_MOV:
            result = srcOp;
         FS_ADD, FS_ADDC, FS_SUB, FS_SUBC, FS_CMP:
         begin
            result    = sum[15:0];
            // Overflow when both inputs share a sign the result lacks
            nextFlags = {(rdB[15] == addB[15]) && (result[15] != rdB[15]), result[15],
                         result == 16'h0, sum[16]};
         end
         FS_BIT, FS_AND:
         begin
            result    = srcOp & rdB;
            nextFlags = {1'b0, result[15], result == 16'h0, result != 16'h0};
         end
         FS_BIC:
            result = rdB & ~srcOp;
         FS_BIS:
            result = rdB | srcOp;
         FS_XOR:
         begin
            result    = srcOp ^ rdB;
            nextFlags = {srcOp[15] & rdB[15], result[15], result == 16'h0, result != 16'h0};
         end
         // Format II works on its single operand, read through rdA
         FS_RRC:
         begin
            result    = {flags[FLAG_C], srcOp[15:1]};
            nextFlags = {1'b0, result[15], result == 16'h0, srcOp[0]};
         end
         FS_RRA:
         begin
            result    = {srcOp[15], srcOp[15:1]};
            nextFlags = {1'b0, result[15], result == 16'h0, srcOp[0]};
         end
         FS_SWPB:
            result = {srcOp[7:0], srcOp[15:8]};
         FS_SXT:
         begin
            result    = {{8{srcOp[7]}}, srcOp[7:0]};
            nextFlags = {1'b0, result[15], result == 16'h0, result != 16'h0};
         end
         // Jump codes leave the flags alone
         default:
            result = rdB;
      endcase
   end

   always_comb
   begin
      case (exec.fs)
         FS_JNE:  condMet = !flags[FLAG_Z];
         FS_JEQ:  condMet = flags[FLAG_Z];
         FS_JNC:  condMet = !flags[FLAG_C];
         FS_JC:   condMet = flags[FLAG_C];
         FS_JN:   condMet = flags[FLAG_N];
         FS_JGE:  condMet = !(flags[FLAG_N] ^ flags[FLAG_V]);
         FS_JL:   condMet = flags[FLAG_N] ^ flags[FLAG_V];
         FS_JMP:  condMet = 1'b1;
         default: condMet = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         exec.done  <= 1'b0;
         exec.taken <= 1'b0;
         wbValid    <= 1'b0;
         wbData     <= '0;
         wbReg      <= '0;
         flags      <= '0;
      end
      else
      begin
         exec.done  <= exec.start;
         exec.taken <= exec.start && condMet;
         // Only writing instructions report a write-back
         wbValid    <= exec.start && exec.regWrite;
         if (exec.start)
         begin
            wbData <= result;
            wbReg  <= exec.dstReg;
            flags  <= nextFlags;
         end
      end
   end

endmodule

/* source/instrDecoder.sv */
// Register and immediate source modes only; other modes are skipped as no-ops
// ROM words arrive with the low-address byte in bits 15:8
module instrDecoder
   (input  logic     clk,
    input  logic     rstN,
    fetchIf.decoder  fetch,
    execIf.decoder   exec);

   import msp430Pkg::*;

   decState_t state;
   // Word with bytes put back in order
   word_t     instr;
   logic [1:0] asBits;
   logic      adBit;
   funcSel_t  decFs;
   regAddr_t  decSrc;
   regAddr_t  decDst;
   logic      decWrite;
   logic      decImm;
   logic      decKnown;

   assign instr  = {fetch.word[7:0], fetch.word[15:8]};
   assign asBits = instr[5:4];
   assign adBit  = instr[7];

   // One cycle of start per instruction
   assign exec.start = (state == EXEC);

   // Format and function decode of the word on the fetch bus
   always_comb
   begin
      decFs    = FS_MOV;
      decSrc   = instr[11:8];
      decDst   = instr[3:0];
      decWrite = 1'b1;
      decImm   = 1'b0;
      decKnown = 1'b1;
      if (instr[15:13] == OP_JUMP)
      begin
         // Jump codes share the 001 prefix
         decFs    = {OP_JUMP, instr[12:10]};
         decWrite = 1'b0;
      end
      else if (instr[15:12] == OP_FMT2)
      begin
         // Single operand works in place
         decSrc = instr[3:0];
         case (instr[15:7])
            OP_RRC:  decFs = FS_RRC;
            OP_SWPB: decFs = FS_SWPB;
            OP_RRA:  decFs = FS_RRA;
            OP_SXT:  decFs = FS_SXT;
            default: decKnown = 1'b0;
         endcase
         if (asBits != 2'b00)
            decKnown = 1'b0;
      end
      else
      begin
         case (instr[15:12])
            OP_MOV:  decFs = FS_MOV;
            OP_ADD:  decFs = FS_ADD;
            OP_ADDC: decFs = FS_ADDC;
            OP_SUBC: decFs = FS_SUBC;
            OP_SUB:  decFs = FS_SUB;
            OP_CMP:  decFs = FS_CMP;
            OP_BIT:  decFs = FS_BIT;
            OP_BIC:  decFs = FS_BIC;
            OP_BIS:  decFs = FS_BIS;
            OP_XOR:  decFs = FS_XOR;
            OP_AND:  decFs = FS_AND;
            default: decKnown = 1'b0;
         endcase
         // Compare and test only touch the flags
         if (instr[15:12] == OP_CMP || instr[15:12] == OP_BIT)
            decWrite = 1'b0;
         // As 11 with R0 is #imm, the next word
         decImm = (asBits == 2'b11) && (instr[11:8] == 4'd0);
         if (adBit || !(asBits == 2'b00 || decImm))
            decKnown = 1'b0;
      end
   end

   // Sequencing and fetch requests
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         state          <= IDLE;
         fetch.wordReq  <= 1'b0;
         fetch.redirect <= 1'b0;
      end
      else
      begin
         fetch.wordReq  <= 1'b0;
         fetch.redirect <= 1'b0;
         case (state)
            IDLE:
            begin
               fetch.wordReq <= 1'b1;
               state         <= WAIT_WORD;
            end
            WAIT_WORD:
            begin
               if (fetch.wordValid)
               begin
                  if (!decKnown)
                     fetch.wordReq <= 1'b1;
                  else if (decImm)
                  begin
                     // Source operand follows in the next word
                     fetch.wordReq <= 1'b1;
                     state         <= WAIT_IMM;
                  end
                  else
                     state <= EXEC;
               end
            end
            WAIT_IMM:
            begin
               if (fetch.wordValid)
                  state <= EXEC;
            end
            EXEC:
               state <= WAIT_DONE;
            WAIT_DONE:
            begin
               if (exec.done)
               begin
                  // taken is only raised for jump codes
                  fetch.redirect <= exec.taken;
                  fetch.wordReq  <= 1'b1;
                  state          <= WAIT_WORD;
               end
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   // Instruction fields held until the next instruction word
   always_ff @(posedge clk)
   begin
      if (state == WAIT_WORD && fetch.wordValid && decKnown)
      begin
         exec.fs       <= decFs;
         exec.srcReg   <= decSrc;
         exec.dstReg   <= decDst;
         exec.regWrite <= decWrite;
         exec.useImm   <= decImm;
         fetch.offset  <= instr[9:0];
      end
      // Immediate uses the same byte order as instructions
      if (state == WAIT_IMM && fetch.wordValid)
         exec.immediate <= instr;
   end

endmodule

/* source/instrFetch.sv */
// Four-phase ROM master; a new memReq waits until memAck has gone low
// Redirect must only arrive while no word is outstanding
module instrFetch
   (input  logic             clk,
    input  logic             rstN,
    fetchIf.fetcher          fetch,
    output logic             memReq,
    output msp430Pkg::word_t memAddr,
    input  logic             memAck,
    input  msp430Pkg::word_t memData);

   import msp430Pkg::*;

   // Request seen from the decoder but not yet on the ROM port
   logic  reqPending;
   // Jump distance in bytes
   word_t jumpStep;

   assign jumpStep = {{5{fetch.offset[9]}}, fetch.offset, 1'b0};

   // Address follows pc, which only moves once memReq is released
   assign memAddr = fetch.pc;

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         memReq          <= 1'b0;
         reqPending      <= 1'b0;
         fetch.wordValid <= 1'b0;
         fetch.pc        <= RESET_PC;
      end
      else
      begin
         // One pulse per completed handshake
         fetch.wordValid <= memReq && memAck;

         if (fetch.wordReq)
            reqPending <= 1'b1;

         if (memReq && memAck)
         begin
            // Release the request, the word is captured below
            memReq   <= 1'b0;
            fetch.pc <= fetch.pc + 16'd2;
         end
         else if (!memReq && reqPending && !memAck)
         begin
            // Previous handshake fully closed
            memReq     <= 1'b1;
            reqPending <= 1'b0;
         end

         // pc already points past the jump word
         if (fetch.redirect)
            fetch.pc <= fetch.pc + jumpStep;
      end
   end

   // Sample data in the cycle the acknowledge is first seen
   always_ff @(posedge clk)
   begin
      if (memReq && memAck)
         fetch.word <= memData;
   end

endmodule

/* source/msp430Core.sv */
// Core top level with one instruction in flight and the ROM behind a four-phase req/ack port
// Programs must keep to R4 to R15; write-back and flags leave through plain ports
module msp430Core
   (input  logic                clk,
    input  logic                rstN,
    output logic                memReq,
    output msp430Pkg::word_t    memAddr,
    input  logic                memAck,
    input  msp430Pkg::word_t    memData,
    output logic                wbValid,
    output msp430Pkg::regAddr_t wbReg,
    output msp430Pkg::word_t    wbData,
    output msp430Pkg::flags_t   flags);

   import msp430Pkg::*;

   // Register reads for the function unit
   word_t rdA;
   word_t rdB;

   fetchIf fetchBus ();
   execIf  execBus ();

   instrFetch u_instrFetch
      (.clk     (clk),
       .rstN    (rstN),
       .fetch   (fetchBus.fetcher),
       .memReq  (memReq),
       .memAddr (memAddr),
       .memAck  (memAck),
       .memData (memData));

   instrDecoder u_instrDecoder
      (.clk   (clk),
       .rstN  (rstN),
       .fetch (fetchBus.decoder),
       .exec  (execBus.decoder));

   // Write data comes back from the function unit
   regFile u_regFile
      (.clk    (clk),
       .rstN   (rstN),
       .exec   (execBus.regs),
       .wbData (wbData),
       .rdA    (rdA),
       .rdB    (rdB));

   // Function unit drives write-back and flags onto the top-level ports
   funcUnit u_funcUnit
      (.clk     (clk),
       .rstN    (rstN),
       .exec    (execBus.alu),
       .rdA     (rdA),
       .rdB     (rdB),
       .wbData  (wbData),
       .wbValid (wbValid),
       .wbReg   (wbReg),
       .flags   (flags));

endmodule

/* source/msp430Pkg.sv */
// Word-wide MSP430 subset; byte mode, DADD, PUSH, CALL and RETI are absent
// Opcode values apply to the byte-swapped instruction word
package msp430Pkg;

   typedef logic [15:0] word_t;
   typedef logic [3:0]  regAddr_t;
   typedef logic [5:0]  funcSel_t;
   // Status flags packed as V, N, Z, C
   typedef logic [3:0]  flags_t;

   localparam int FLAG_V = 3;
   localparam int FLAG_N = 2;
   localparam int FLAG_Z = 1;
   localparam int FLAG_C = 0;

   // First fetch address after reset
   localparam word_t RESET_PC = 16'h0000;
   // Lowest implemented register
   localparam regAddr_t LOW_REG = 4'd4;

   // Format I opcodes in bits 15:12
   localparam logic [3:0] OP_MOV  = 4'h4;
   localparam logic [3:0] OP_ADD  = 4'h5;
   localparam logic [3:0] OP_ADDC = 4'h6;
   localparam logic [3:0] OP_SUBC = 4'h7;
   localparam logic [3:0] OP_SUB  = 4'h8;
   localparam logic [3:0] OP_CMP  = 4'h9;
   localparam logic [3:0] OP_BIT  = 4'hB;
   localparam logic [3:0] OP_BIC  = 4'hC;
   localparam logic [3:0] OP_BIS  = 4'hD;
   localparam logic [3:0] OP_XOR  = 4'hE;
   localparam logic [3:0] OP_AND  = 4'hF;
   // Format II words start with 0001 in bits 15:12
   localparam logic [3:0] OP_FMT2 = 4'h1;
   // Format II opcodes in bits 15:7
   localparam logic [8:0] OP_RRC  = 9'h020;
   localparam logic [8:0] OP_SWPB = 9'h021;
   localparam logic [8:0] OP_RRA  = 9'h022;
   localparam logic [8:0] OP_SXT  = 9'h023;
   // Jump prefix in bits 15:13
   localparam logic [2:0] OP_JUMP = 3'b001;

   // Jump codes are 001 followed by the condition bits
   localparam funcSel_t FS_JNE  = 6'h08;
   localparam funcSel_t FS_JEQ  = 6'h09;
   localparam funcSel_t FS_JNC  = 6'h0A;
   localparam funcSel_t FS_JC   = 6'h0B;
   localparam funcSel_t FS_JN   = 6'h0C;
   localparam funcSel_t FS_JGE  = 6'h0D;
   localparam funcSel_t FS_JL   = 6'h0E;
   localparam funcSel_t FS_JMP  = 6'h0F;
   localparam funcSel_t FS_MOV  = 6'h10;
   localparam funcSel_t FS_ADD  = 6'h11;
   localparam funcSel_t FS_ADDC = 6'h12;
   localparam funcSel_t FS_SUBC = 6'h13;
   localparam funcSel_t FS_SUB  = 6'h14;
   localparam funcSel_t FS_CMP  = 6'h15;
   localparam funcSel_t FS_BIT  = 6'h16;
   localparam funcSel_t FS_BIC  = 6'h17;
   localparam funcSel_t FS_BIS  = 6'h18;
   localparam funcSel_t FS_XOR  = 6'h19;
   localparam funcSel_t FS_AND  = 6'h1A;
   localparam funcSel_t FS_RRC  = 6'h20;
   localparam funcSel_t FS_SWPB = 6'h21;
   localparam funcSel_t FS_RRA  = 6'h22;
   localparam funcSel_t FS_SXT  = 6'h23;

   typedef enum logic [2:0] {IDLE, WAIT_WORD, WAIT_IMM, EXEC, WAIT_DONE} decState_t;

endpackage

/* source/regFile.sv */
// R4 to R15 only; reads of R0 to R3 return zero and writes to them are dropped
module regFile
   (input  logic             clk,
    input  logic             rstN,
    execIf.regs              exec,
    input  msp430Pkg::word_t wbData,
    output msp430Pkg::word_t rdA,
    output msp430Pkg::word_t rdB);

   import msp430Pkg::*;

   word_t regs [LOW_REG:15];
   logic  writeEn;

   // Write-back lands in the done cycle
   assign writeEn = exec.done && exec.regWrite && (exec.dstReg >= LOW_REG);

   // Asynchronous read, sampled by the function unit on start
   assign rdA = (exec.srcReg >= LOW_REG) ? regs[exec.srcReg] : '0;
   assign rdB = (exec.dstReg >= LOW_REG) ? regs[exec.dstReg] : '0;

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         for (int i = LOW_REG; i <= 15; i++)
            regs[i] <= '0;
      end
      else if (writeEn)
         regs[exec.dstReg] <= wbData;
   end

endmodule

/* testbench/msp430CoreChecker_checker.sv */
// Protocol assertions bound into the core; start and done are taken from the internal execIf
module msp430CoreChecker
   (input logic             clk,
    input logic             rstN,
    input logic             memReq,
    input msp430Pkg::word_t memAddr,
    input logic             memAck,
    input logic             start,
    input logic             done,
    input logic             wbValid);

   // Address held while the ROM has not answered
   addrStable: assert property (@(posedge clk) disable iff (!rstN)
      memReq && !memAck |=> memAddr == $past(memAddr))
      else $error("memAddr moved while a ROM request was open");

   // New request only once the previous acknowledge is gone
   reqAfterAckLow: assert property (@(posedge clk) disable iff (!rstN)
      $rose(memReq) |-> !$past(memAck))
      else $error("memReq rose while memAck was still high");

   // Fixed one-cycle function unit latency
   doneAfterStart: assert property (@(posedge clk) disable iff (!rstN)
      start |=> done)
      else $error("done did not follow start by one cycle");

   noStrayDone: assert property (@(posedge clk) disable iff (!rstN)
      done |-> $past(start))
      else $error("done came without a start one cycle before");

   // Write-back is a done cycle event
   wbWithDone: assert property (@(posedge clk) disable iff (!rstN)
      wbValid |-> done)
      else $error("wbValid came outside a done cycle");

endmodule

bind msp430Core msp430CoreChecker u_checker
   (.clk     (clk),
    .rstN    (rstN),
    .memReq  (memReq),
    .memAddr (memAddr),
    .memAck  (memAck),
    .start   (execBus.start),
    .done    (execBus.done),
    .wbValid (wbValid));

/* testbench/msp430CoreTb.sv */
// Random program on R4 to R15 from seed 79, checked against a reference model
// The program ends in a self-jump; the run stops once that jump has been fetched twice
module msp430CoreTb;

   import msp430Pkg::*;

   logic     clk;
   logic     rstN;
   logic     memReq;
   word_t    memAddr;
   logic     memAck;
   word_t    memData;
   logic     wbValid;
   regAddr_t wbReg;
   word_t    wbData;
   flags_t   flags;

   // ROM contents as they appear on the bus, low-address byte on top
   word_t  rom [0:255];
   integer seed;
   int     wp;
   word_t  setupEnd;
   word_t  selfAddr;
   int     nInstr;
   // Expected fetch address, flags at that fetch, and the test of the instruction before it
   word_t  fAddr [$];
   flags_t fFlags [$];
   int     fTest [$];
   // Expected write-backs as register and value
   logic [19:0] wbExp [$];
   int          wbTest [$];
   int fetchIdx;
   int wbIdx;
   int cycles;
   int cycleLimit;
   int checks [1:5];
   int errs [1:5];

   msp430Core u_msp430Core (.*);

   always #50 clk = ~clk;

   function automatic word_t swapBytes(input word_t w);
      return {w[7:0], w[15:8]};
   endfunction

   function automatic regAddr_t randReg();
      return regAddr_t'(4 + $unsigned($random(seed)) % 12);
   endfunction

   function automatic string testLabel(input int t);
      case (t)
         1: return "immediate loads";
         2: return "format I";
         3: return "format II";
         4: return "jumps";
         default: return "handshake";
      endcase
   endfunction

   task automatic reportValue(input int t, input string what, input logic [19:0] expV,
                              input logic [19:0] actV);
      errs[t]++;
      $display("Error %s %s: expected %h, actual %h", testLabel(t), what, expV, actV);
   endtask

   task automatic putWord(input word_t instr);
      rom[wp] = swapBytes(instr);
      wp++;
   endtask

   // One non-jump instruction; oneWord keeps it to a single word
   task automatic putOp(input bit oneWord);
      logic [3:0] fmt1Ops [0:10];
      logic [3:0] op;
      regAddr_t   dst;
      int         pick;
      fmt1Ops = '{OP_MOV, OP_ADD, OP_ADDC, OP_SUBC, OP_SUB, OP_CMP, OP_BIT, OP_BIC,
                  OP_BIS, OP_XOR, OP_AND};
      pick = $unsigned($random(seed)) % 8;
      dst  = randReg();
      op   = fmt1Ops[$unsigned($random(seed)) % 11];
      if (pick < 5)
      begin
         if (!oneWord && pick == 0)
         begin
            putWord({op, 4'd0, 2'b00, 2'b11, dst});
            putWord(word_t'($random(seed)));
         end
         else
            putWord({op, randReg(), 2'b00, 2'b00, dst});
      end
      else
         putWord({OP_RRC + 9'($unsigned($random(seed)) % 4), 3'b000, dst});
   endtask

   task automatic buildProgram();
      int skip;
      for (int i = 0; i < 256; i++)
         rom[i] = word_t'($random(seed));
      wp = 0;
      // Setup loads every register from an immediate
      for (int r = 4; r <= 15; r++)
      begin
         putWord({OP_MOV, 4'd0, 2'b00, 2'b11, 4'(r)});
         putWord(word_t'($random(seed)));
      end
      setupEnd = word_t'(wp * 2);
      while (wp < 236)
      begin
         if ($unsigned($random(seed)) % 6 == 0)
         begin
            // Forward jump over single-word fillers only
            skip = 1 + $unsigned($random(seed)) % 3;
            putWord({OP_JUMP, 3'($unsigned($random(seed)) % 8), 10'(skip)});
            for (int k = 0; k < skip; k++)
               putOp(1'b1);
         end
         else
            putOp(1'b0);
      end
      selfAddr = word_t'(wp * 2);
      putWord({OP_JUMP, 3'b111, 10'h3FF});
   endtask

   task automatic addFetch(input word_t a, input flags_t f, input int t);
      fAddr.push_back(a);
      fFlags.push_back(f);
      fTest.push_back(t);
   endtask

   // Walks the ROM word by word with MSP430 word semantics
   task automatic runModel();
      word_t       regs [0:15];
      word_t       pc;
      word_t       here;
      word_t       instr;
      word_t       src;
      word_t       d;
      word_t       b;
      word_t       res;
      logic [16:0] sum;
      logic        cin;
      logic        taken;
      logic        write;
      flags_t      fl;
      int          cat;
      bit          stop;
      for (int i = 0; i < 16; i++)
         regs[i] = '0;
      pc   = RESET_PC;
      fl   = '0;
      cat  = 0;
      stop = 0;
      while (!stop)
      begin
         addFetch(pc, fl, cat);
         here  = pc;
         instr = swapBytes(rom[pc[8:1]]);
         pc    = pc + 16'd2;
         nInstr++;
         write = 1'b0;
         if (instr[15:13] == OP_JUMP)
         begin
            cat = 4;
            case (instr[12:10])
               3'd0: taken = !fl[FLAG_Z];
               3'd1: taken = fl[FLAG_Z];
               3'd2: taken = !fl[FLAG_C];
               3'd3: taken = fl[FLAG_C];
               3'd4: taken = fl[FLAG_N];
               3'd5: taken = !(fl[FLAG_N] ^ fl[FLAG_V]);
               3'd6: taken = fl[FLAG_N] ^ fl[FLAG_V];
               default: taken = 1'b1;
            endcase
            if (taken)
               pc = pc + {{5{instr[9]}}, instr[9:0], 1'b0};
            if (here == selfAddr)
            begin
               addFetch(pc, fl, cat);
               stop = 1;
            end
         end
         else if (instr[15:12] == OP_FMT2)
         begin
            cat   = 3;
            write = 1'b1;
            d     = regs[instr[3:0]];
            case (instr[15:7])
               OP_RRC:  res = {fl[FLAG_C], d[15:1]};
               OP_RRA:  res = {d[15], d[15:1]};
               OP_SWPB: res = {d[7:0], d[15:8]};
               default: res = {{8{d[7]}}, d[7:0]};
            endcase
            if (instr[15:7] == OP_RRC || instr[15:7] == OP_RRA)
               fl = {1'b0, res[15], res == 16'h0, d[0]};
            else if (instr[15:7] == OP_SXT)
               fl = {1'b0, res[15], res == 16'h0, res != 16'h0};
         end
         else
         begin
            cat   = (here < setupEnd) ? 1 : 2;
            write = 1'b1;
            if (instr[5:4] == 2'b11)
            begin
               // Immediate word fetched before the operation runs
               addFetch(pc, fl, 0);
               src = swapBytes(rom[pc[8:1]]);
               pc  = pc + 16'd2;
            end
            else
               src = regs[instr[11:8]];
            d = regs[instr[3:0]];
            case (instr[15:12])
               OP_MOV:
                  res = src;
               OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_CMP:
               begin
                  // Subtraction as d + ~s + carry-in, C means no borrow
                  b = (instr[15:12] == OP_ADD || instr[15:12] == OP_ADDC) ? src : ~src;
                  if (instr[15:12] == OP_ADD)
                     cin = 1'b0;
                  else if (instr[15:12] == OP_SUB || instr[15:12] == OP_CMP)
                     cin = 1'b1;
                  else
                     cin = fl[FLAG_C];
                  sum   = {1'b0, d} + {1'b0, b} + {16'h0, cin};
                  res   = sum[15:0];
                  fl    = {(d[15] == b[15]) && (res[15] != d[15]), res[15], res == 16'h0,
                           sum[16]};
                  write = (instr[15:12] != OP_CMP);
               end
               OP_BIT, OP_AND:
               begin
                  res   = src & d;
                  fl    = {1'b0, res[15], res == 16'h0, res != 16'h0};
                  write = (instr[15:12] == OP_AND);
               end
               OP_BIC:
                  res = d & ~src;
               OP_BIS:
                  res = d | src;
               default:
               begin
                  res = src ^ d;
                  fl  = {src[15] & d[15], res[15], res == 16'h0, res != 16'h0};
               end
            endcase
         end
         if (write)
         begin
            regs[instr[3:0]] = res;
            wbExp.push_back({instr[3:0], res});
            wbTest.push_back(cat);
         end
      end
   endtask

   // Address and flags at each new ROM request
   task automatic checkFetch();
      int t;
      if (fetchIdx >= fAddr.size())
         return;
      t = (fTest[fetchIdx] == 4) ? 4 : 5;
      checks[t]++;
      assert (memAddr == fAddr[fetchIdx])
         else reportValue(t, "fetch address", fAddr[fetchIdx], memAddr);
      t = (fTest[fetchIdx] == 0) ? 5 : fTest[fetchIdx];
      checks[t]++;
      assert (flags == fFlags[fetchIdx])
         else reportValue(t, "flags", fFlags[fetchIdx], flags);
      fetchIdx++;
   endtask

   // ROM responder with 0 to 3 cycles of acknowledge delay
   initial
   begin : romResponder
      int delay;
      forever
      begin
         @(posedge clk);
         #1;
         if (rstN && memReq && !memAck)
         begin
            checkFetch();
            delay = $unsigned($random(seed)) % 4;
            repeat (delay)
            begin
               @(posedge clk);
               #1;
            end
            memData = rom[memAddr[8:1]];
            memAck  = 1'b1;
            while (memReq)
            begin
               @(posedge clk);
               #1;
            end
            memAck = 1'b0;
         end
      end
   end

   // Write-back order and values
   always @(negedge clk)
   begin
      if (rstN && wbValid)
      begin
         checks[5]++;
         assert (wbIdx < wbExp.size())
            else
            begin
               errs[5]++;
               $display("Extra write-back to R%0d after the last expected one", wbReg);
            end
         if (wbIdx < wbExp.size())
         begin
            checks[wbTest[wbIdx]]++;
            assert ({wbReg, wbData} == wbExp[wbIdx])
               else reportValue(wbTest[wbIdx], "write-back", wbExp[wbIdx], {wbReg, wbData});
            wbIdx++;
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycleLimit > 0 && cycles > cycleLimit)
      begin
         $display("Timeout: the final self-jump was not fetched within %0d cycles", cycleLimit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial
   begin : mainFlow
      int totalChecks;
      int totalErrs;
      clk     = 1'b0;
      rstN    = 1'b0;
      memAck  = 1'b0;
      memData = '0;
      seed    = 79;
      buildProgram();
      runModel();
      // Margin covers the extra word of immediate instructions
      cycleLimit = nInstr * 12 + fAddr.size() * 8 + 100;
      repeat (4) @(posedge clk);
      #1;
      rstN = 1'b1;
      while (fetchIdx < fAddr.size())
         @(posedge clk);
      repeat (4) @(posedge clk);
      checks[5]++;
      assert (wbIdx == wbExp.size())
         else reportValue(5, "write-back count", wbExp.size(), wbIdx);
      totalChecks = 0;
      totalErrs   = 0;
      for (int t = 1; t <= 5; t++)
      begin
         $display("Test %0d %s: %0d checks, %0d errors", t, testLabel(t), checks[t], errs[t]);
         totalChecks += checks[t];
         totalErrs   += errs[t];
      end
      $display("Total: %0d checks, %0d errors", totalChecks, totalErrs);
      if (totalErrs == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
